//--- rtl/lsu_consts.svh
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// datapath width of the 64-bit core
`define LSU_GRLEN 64

// one result lane per byte of the word
`define LSU_LANES 8

// bits carried by a lane
`define LSU_BYTE_W 8

// byte offset inside the read word
`define LSU_SHIFT_W 3

// encoded opcode width, room for the reduced set
`define LSU_OP_W 5

`endif

//--- rtl/lsu_op_pkg.sv
`default_nettype none

`include "lsu_consts.svh"

package lsu_op_pkg;

  // reduced load/store opcode set handled by the second stage
  typedef enum logic [`LSU_OP_W-1:0] {
    IDLE  = 5'd0,
    // plain loads, signed and unsigned
    LD_B  = 5'd1,
    LD_BU = 5'd2,
    LD_H  = 5'd3,
    LD_HU = 5'd4,
    LD_W  = 5'd5,
    LD_WU = 5'd6,
    LD_D  = 5'd7,
    // stores return only the sc flag
    ST_B  = 5'd8,
    ST_H  = 5'd9,
    ST_W  = 5'd10,
    ST_D  = 5'd11,
    // load-linked behaves like a signed load
    LL_W  = 5'd12,
    LL_D  = 5'd13,
    // store-conditional reports success in bit 0
    SC_W  = 5'd14,
    SC_D  = 5'd15,
    // prefetch completes without waiting on the cache
    PRELD = 5'd16
  } lsu_op_e;

  // access size, encoded as log2 of the byte count
  typedef enum logic [1:0] {
    SIZE_B = 2'd0,
    SIZE_H = 2'd1,
    SIZE_W = 2'd2,
    SIZE_D = 2'd3
  } lsu_size_e;

endpackage

`default_nettype wire

//--- rtl/lsu_mem_pkg.sv
`default_nettype none

`include "lsu_consts.svh"

package lsu_mem_pkg;

  // full read word from the data cache
  typedef logic [`LSU_GRLEN-1:0] lsu_word_t;

  // a single byte lane of the result
  typedef logic [`LSU_BYTE_W-1:0] lsu_byte_t;

  // byte offset of the access within the word
  typedef logic [`LSU_SHIFT_W-1:0] lsu_shift_t;

endpackage

`default_nettype wire

//--- rtl/lsu_lane_if.sv
`default_nettype none

`include "lsu_consts.svh"

// steering info from the decoder, shared by all byte lanes
interface lsu_lane_if;

  lsu_mem_pkg::lsu_word_t  rdata;
  lsu_mem_pkg::lsu_shift_t shift;
  lsu_op_pkg::lsu_size_e   size;
  logic                    is_load;

  modport feed (
    output rdata, shift, size, is_load
  );

  // every lane sees the same word and offset
  modport lane (
    input rdata, shift, size, is_load
  );

endinterface

// lane results plus the extension controls, drained by the merge block
interface lsu_merge_if;

  // lane i only ever writes element i
  lsu_mem_pkg::lsu_byte_t  lane_byte [`LSU_LANES];
  logic [`LSU_LANES-1:0]   in_field;
  logic                    is_load;
  logic                    is_unsigned;
  lsu_op_pkg::lsu_size_e   size;

  modport lane (
    output lane_byte, in_field
  );

  // decoder side, same modport name as on the steering bus
  modport feed (
    output is_load, is_unsigned, size
  );

  modport drain (
    input lane_byte, in_field, is_load, is_unsigned, size
  );

endinterface

`default_nettype wire

//--- rtl/lsu_op_decode.sv
`default_nettype none

module lsu_op_decode (
  input  lsu_op_pkg::lsu_op_e     lsu_op,
  input  lsu_mem_pkg::lsu_word_t  data_rdata,
  input  lsu_mem_pkg::lsu_shift_t lsu_shift,
  lsu_lane_if.feed                lane_feed,
  lsu_merge_if.feed               merge_feed,
  output logic                    is_prefetch,
  output logic                    is_idle
);

  lsu_op_pkg::lsu_size_e op_size;
  logic                  op_load;
  logic                  op_unsigned;

  // opcode to size / load / signedness
  always_comb begin
    // defaults cover idle, preld and any unused code
    op_size     = lsu_op_pkg::SIZE_B;
    op_load     = 1'b0;
    op_unsigned = 1'b0;
    unique case (lsu_op)
      lsu_op_pkg::LD_B: begin
        op_load = 1'b1;
      end
      lsu_op_pkg::LD_BU: begin
        op_load     = 1'b1;
        op_unsigned = 1'b1;
      end
      lsu_op_pkg::LD_H: begin
        op_size = lsu_op_pkg::SIZE_H;
        op_load = 1'b1;
      end
      lsu_op_pkg::LD_HU: begin
        op_size     = lsu_op_pkg::SIZE_H;
        op_load     = 1'b1;
        op_unsigned = 1'b1;
      end
      // ll.w sign-extends like ld.w
      lsu_op_pkg::LD_W, lsu_op_pkg::LL_W: begin
        op_size = lsu_op_pkg::SIZE_W;
        op_load = 1'b1;
      end
      lsu_op_pkg::LD_WU: begin
        op_size     = lsu_op_pkg::SIZE_W;
        op_load     = 1'b1;
        op_unsigned = 1'b1;
      end
      lsu_op_pkg::LD_D, lsu_op_pkg::LL_D: begin
        op_size = lsu_op_pkg::SIZE_D;
        op_load = 1'b1;
      end
      // stores and sc keep their size but are not loads
      lsu_op_pkg::ST_H: op_size = lsu_op_pkg::SIZE_H;
      lsu_op_pkg::ST_W, lsu_op_pkg::SC_W: op_size = lsu_op_pkg::SIZE_W;
      lsu_op_pkg::ST_D, lsu_op_pkg::SC_D: op_size = lsu_op_pkg::SIZE_D;
      default: op_size = lsu_op_pkg::SIZE_B;
    endcase
  end

  // steering for the lanes
  assign lane_feed.rdata   = data_rdata;
  assign lane_feed.shift   = lsu_shift;
  assign lane_feed.size    = op_size;
  assign lane_feed.is_load = op_load;

  // extension controls for the merge
  assign merge_feed.is_load     = op_load;
  assign merge_feed.is_unsigned = op_unsigned;
  assign merge_feed.size        = op_size;

  // flags used by completion tracking
  assign is_prefetch = (lsu_op == lsu_op_pkg::PRELD);
  assign is_idle     = (lsu_op == lsu_op_pkg::IDLE);

endmodule

`default_nettype wire

//--- rtl/lsu_byte_lane.sv
`default_nettype none

`include "lsu_consts.svh"

module lsu_byte_lane #(
  parameter int LANE = 0
) (
  lsu_lane_if.lane  lane,
  lsu_merge_if.lane result
);

  lsu_mem_pkg::lsu_shift_t src_idx;
  logic [3:0]              field_bytes;

  // rotate by the access offset, wraps mod 8
  assign src_idx = lane.shift + LANE[`LSU_SHIFT_W-1:0];

  // bytes covered by the access, 1/2/4/8
  assign field_bytes = 4'd1 << lane.size;

  // pick the source byte for this result lane
  assign result.lane_byte[LANE] = lane.rdata[src_idx * `LSU_BYTE_W +: `LSU_BYTE_W];

  // lane belongs to the loaded field only on loads
  assign result.in_field[LANE] = lane.is_load && (LANE < int'(field_bytes));

endmodule

`default_nettype wire

//--- rtl/lsu_result_merge.sv
`default_nettype none

`include "lsu_consts.svh"

module lsu_result_merge (
  lsu_merge_if.drain              lanes,
  input  logic                    data_scsucceed,
  output lsu_mem_pkg::lsu_word_t  read_result
);

  logic [$clog2(`LSU_LANES)-1:0] top_lane;
  logic                          sign_bit;
  lsu_mem_pkg::lsu_byte_t        fill_byte;
  lsu_mem_pkg::lsu_word_t        load_word;

  // highest lane inside the field holds the sign
  always_comb begin
    unique case (lanes.size)
      lsu_op_pkg::SIZE_B: top_lane = 3'd0;
      lsu_op_pkg::SIZE_H: top_lane = 3'd1;
      lsu_op_pkg::SIZE_W: top_lane = 3'd3;
      default:            top_lane = 3'd7;
    endcase
  end

  assign sign_bit = lanes.lane_byte[top_lane][`LSU_BYTE_W-1];

  // bytes above the field: zeros or sign copies
  assign fill_byte = lanes.is_unsigned ? '0 : {`LSU_BYTE_W{sign_bit}};

  // in-field lanes pass through, the rest get the fill
  always_comb begin
    for (int i = 0; i < `LSU_LANES; i++) begin
      if (lanes.in_field[i]) begin
        load_word[i*`LSU_BYTE_W +: `LSU_BYTE_W] = lanes.lane_byte[i];
      end else begin
        load_word[i*`LSU_BYTE_W +: `LSU_BYTE_W] = fill_byte;
      end
    end
  end

  // stores and sc only report the success flag in bit 0
  assign read_result = lanes.is_load ? load_word
                                     : lsu_mem_pkg::lsu_word_t'(data_scsucceed);

endmodule

`default_nettype wire

//--- rtl/lsu_resp_ctrl.sv
`default_nettype none

module lsu_resp_ctrl (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   valid,
  input  logic                   lsu_recv,
  input  logic                   data_data_ok,
  input  logic                   data_exception,
  input  lsu_mem_pkg::lsu_word_t data_badvaddr,
  input  logic                   is_prefetch,
  input  logic                   is_idle,
  input  logic                   change,
  input  logic                   exception,
  output logic                   data_recv,
  output logic                   lsu_res_valid,
  output lsu_mem_pkg::lsu_word_t badvaddr,
  output logic                   badvaddr_valid
);

  logic res_held;
  logic resp_event;
  logic capture_allow;
  logic fault;

  // anything that completes the access this cycle
  assign resp_event = data_data_ok || data_exception || is_prefetch;

  // result stays valid until the consumer moves on with change
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res_held <= 1'b0;
    end else if (change) begin
      res_held <= 1'b0;
    end else if (resp_event) begin
      res_held <= 1'b1;
    end
  end

  // stop taking new data from the cache once a result is held
  assign data_recv = lsu_recv && !res_held;

  // no access in flight also counts as done
  assign lsu_res_valid = resp_event || res_held || !valid || is_idle;

  // only faults of a live access are recorded
  assign fault = data_exception && valid;

  // first fault closes the window, exception reopens it
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      capture_allow <= 1'b1;
    end else if (exception) begin
      capture_allow <= 1'b1;
    end else if (fault) begin
      capture_allow <= 1'b0;
    end
  end

  // keep the address of the first fault only
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      badvaddr <= '0;
    end else if (fault && capture_allow) begin
      badvaddr <= data_badvaddr;
    end
  end

  assign badvaddr_valid = !capture_allow;

endmodule

`default_nettype wire

//--- rtl/lsu_s2_top.sv
`default_nettype none

`include "lsu_consts.svh"

module lsu_s2_top (
  input  logic                    clk,
  input  logic                    rst_n,

  input  logic                    valid,
  input  lsu_op_pkg::lsu_op_e     lsu_op,
  input  logic                    lsu_recv,
  input  lsu_mem_pkg::lsu_shift_t lsu_shift,

  // data cache response
  output logic                    data_recv,
  input  logic                    data_scsucceed,
  input  lsu_mem_pkg::lsu_word_t  data_rdata,
  input  logic                    data_exception,
  input  lsu_mem_pkg::lsu_word_t  data_badvaddr,
  input  logic                    data_data_ok,

  // aligned result towards writeback
  output lsu_mem_pkg::lsu_word_t  read_result,
  output logic                    lsu_res_valid,

  // pipeline flush and fault address
  input  logic                    change,
  input  logic                    exception,
  output lsu_mem_pkg::lsu_word_t  badvaddr,
  output logic                    badvaddr_valid
);

  logic is_prefetch;
  logic is_idle;

  lsu_lane_if  lane_bus ();
  lsu_merge_if merge_bus ();

  // opcode decode, drives both buses
  lsu_op_decode u_decode (
    .lsu_op      (lsu_op),
    .data_rdata  (data_rdata),
    .lsu_shift   (lsu_shift),
    .lane_feed   (lane_bus.feed),
    .merge_feed  (merge_bus.feed),
    .is_prefetch (is_prefetch),
    .is_idle     (is_idle)
  );

  // one lane per result byte
  for (genvar i = 0; i < `LSU_LANES; i++) begin : g_lane
    lsu_byte_lane #(
      .LANE (i)
    ) u_lane (
      .lane   (lane_bus.lane),
      .result (merge_bus.lane)
    );
  end

  // field merge and extension
  lsu_result_merge u_merge (
    .lanes          (merge_bus.drain),
    .data_scsucceed (data_scsucceed),
    .read_result    (read_result)
  );

  // completion and fault capture
  lsu_resp_ctrl u_resp (
    .clk            (clk),
    .rst_n          (rst_n),
    .valid          (valid),
    .lsu_recv       (lsu_recv),
    .data_data_ok   (data_data_ok),
    .data_exception (data_exception),
    .data_badvaddr  (data_badvaddr),
    .is_prefetch    (is_prefetch),
    .is_idle        (is_idle),
    .change         (change),
    .exception      (exception),
    .data_recv      (data_recv),
    .lsu_res_valid  (lsu_res_valid),
    .badvaddr       (badvaddr),
    .badvaddr_valid (badvaddr_valid)
  );

endmodule

`default_nettype wire

//--- test/tb_lsu_s2.sv
`default_nettype none

module tb_lsu_s2;
  timeunit 1ns;
  timeprecision 100ps;

  logic                    clk;
  logic                    rst_n;
  logic                    valid;
  lsu_op_pkg::lsu_op_e     lsu_op;
  logic                    lsu_recv;
  lsu_mem_pkg::lsu_shift_t lsu_shift;
  logic                    data_recv;
  logic                    data_scsucceed;
  lsu_mem_pkg::lsu_word_t  data_rdata;
  logic                    data_exception;
  lsu_mem_pkg::lsu_word_t  data_badvaddr;
  logic                    data_data_ok;
  lsu_mem_pkg::lsu_word_t  read_result;
  logic                    lsu_res_valid;
  logic                    change;
  logic                    exception;
  lsu_mem_pkg::lsu_word_t  badvaddr;
  logic                    badvaddr_valid;

  integer seed;
  int     err_count;
  int     check_count;
  int     timeout_count;

  lsu_s2_top DUT (
    .clk            (clk),
    .rst_n          (rst_n),
    .valid          (valid),
    .lsu_op         (lsu_op),
    .lsu_recv       (lsu_recv),
    .lsu_shift      (lsu_shift),
    .data_recv      (data_recv),
    .data_scsucceed (data_scsucceed),
    .data_rdata     (data_rdata),
    .data_exception (data_exception),
    .data_badvaddr  (data_badvaddr),
    .data_data_ok   (data_data_ok),
    .read_result    (read_result),
    .lsu_res_valid  (lsu_res_valid),
    .change         (change),
    .exception      (exception),
    .badvaddr       (badvaddr),
    .badvaddr_valid (badvaddr_valid)
  );

  // 100 ns period
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // hard stop in case a test loop never returns
  initial begin
    #400000;
    $display("timeout: simulation ran past its cycle limit");
    $display("Verification failed");
    $finish;
  end

  // field of nbytes at byte offset shift, extended to 64 bits
  function automatic logic [63:0] expected_load(input logic [63:0] word, input int shift,
                                                input int nbytes, input bit sign_ext);
    logic [63:0] res;
    logic        top;
    res = '0;
    for (int b = 0; b < nbytes; b++) begin
      res[b*8 +: 8] = word[(shift+b)*8 +: 8];
    end
    top = res[nbytes*8-1];
    if (sign_ext) begin
      for (int k = nbytes*8; k < 64; k++) begin
        res[k] = top;
      end
    end
    return res;
  endfunction

  task automatic check_word(input string name, input logic [63:0] exp, input logic [63:0] act);
    check_count++;
    assert (act === exp) else begin
      err_count++;
      $display("FAIL t=%0t %s expected=%h actual=%h", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    check_count++;
    assert (act === exp) else begin
      err_count++;
      $display("FAIL t=%0t %s expected=%b actual=%b", $time, name, exp, act);
    end
  endtask

  // sample once per cycle on the falling edge, bounded
  task automatic wait_fault_flag(input logic level, input int max_cycles, output int cycles);
    bit reached;
    reached = 1'b0;
    cycles  = 0;
    while (!reached && cycles < max_cycles) begin
      @(negedge clk);
      cycles++;
      if (badvaddr_valid === level) reached = 1'b1;
    end
    if (!reached) begin
      timeout_count++;
      $display("timeout: badvaddr_valid never reached %0b within %0d cycles", level, max_cycles);
    end
  endtask

  // held result must drop after change, bounded
  task automatic wait_released(input int max_cycles);
    int  cycles;
    bit  reached;
    reached = 1'b0;
    cycles  = 0;
    while (!reached && cycles < max_cycles) begin
      @(negedge clk);
      cycles++;
      if (lsu_res_valid === 1'b0) reached = 1'b1;
    end
    if (!reached) begin
      timeout_count++;
      $display("timeout: lsu_res_valid stayed high %0d cycles after change", max_cycles);
    end
    // one cycle of change is enough to drop the held flag
    check_word("lsu_res_valid latency", 64'd1, 64'(cycles));
    check_bit("data_recv", lsu_recv, data_recv);
  endtask

  task automatic pulse_change();
    @(posedge clk) change <= 1'b1;
    @(posedge clk) change <= 1'b0;
  endtask

  task automatic pulse_exception();
    @(posedge clk) exception <= 1'b1;
    @(posedge clk) exception <= 1'b0;
  endtask

  // one faulting cycle with capture open, flag one cycle later
  task automatic raise_fault(input logic [63:0] addr);
    int cycles;
    @(posedge clk);
    data_exception <= 1'b1;
    data_badvaddr  <= addr;
    @(negedge clk);
    check_bit("badvaddr_valid", 1'b0, badvaddr_valid);
    @(posedge clk) data_exception <= 1'b0;
    wait_fault_flag(1'b1, 4, cycles);
    check_word("badvaddr_valid latency", 64'd1, 64'(cycles));
    check_word("badvaddr", addr, badvaddr);
  endtask

  task automatic test_reset_state();
    check_bit("lsu_res_valid", 1'b1, lsu_res_valid);
    check_bit("badvaddr_valid", 1'b0, badvaddr_valid);
    check_word("badvaddr", 64'd0, badvaddr);
    // data_recv tracks lsu_recv both ways
    @(posedge clk) lsu_recv <= 1'b0;
    @(negedge clk) check_bit("data_recv", 1'b0, data_recv);
    @(posedge clk) lsu_recv <= 1'b1;
    @(negedge clk) check_bit("data_recv", 1'b1, data_recv);
  endtask

  // every aligned shift of one load opcode, a few random words each
  task automatic run_load_op(input lsu_op_pkg::lsu_op_e op, input int nbytes, input bit sign_ext);
    logic [63:0] word;
    for (int sh = 0; sh < 8; sh += nbytes) begin
      for (int n = 0; n < 4; n++) begin
        word = {$random(seed), $random(seed)};
        // force the sign bit both ways across the runs
        word[(sh+nbytes)*8-1] = n[0];
        @(posedge clk);
        lsu_op     <= op;
        lsu_shift  <= sh[2:0];
        data_rdata <= word;
        @(negedge clk);
        check_word("read_result", expected_load(word, sh, nbytes, sign_ext), read_result);
      end
    end
  endtask

  task automatic test_loads();
    run_load_op(lsu_op_pkg::LD_B, 1, 1'b1);
    run_load_op(lsu_op_pkg::LD_BU, 1, 1'b0);
    run_load_op(lsu_op_pkg::LD_H, 2, 1'b1);
    run_load_op(lsu_op_pkg::LD_HU, 2, 1'b0);
    run_load_op(lsu_op_pkg::LD_W, 4, 1'b1);
    run_load_op(lsu_op_pkg::LD_WU, 4, 1'b0);
    run_load_op(lsu_op_pkg::LD_D, 8, 1'b1);
    run_load_op(lsu_op_pkg::LL_W, 4, 1'b1);
    run_load_op(lsu_op_pkg::LL_D, 8, 1'b1);
  endtask

  // stores and sc only report the success flag
  task automatic run_nonload_op(input lsu_op_pkg::lsu_op_e op);
    logic [63:0] exp;
    for (int sc = 0; sc < 2; sc++) begin
      exp    = '0;
      exp[0] = sc[0];
      @(posedge clk);
      lsu_op         <= op;
      lsu_shift      <= 3'($random(seed));
      data_rdata     <= {$random(seed), $random(seed)};
      data_scsucceed <= sc[0];
      @(negedge clk);
      check_word("read_result", exp, read_result);
    end
  endtask

  task automatic test_nonloads();
    run_nonload_op(lsu_op_pkg::ST_B);
    run_nonload_op(lsu_op_pkg::ST_H);
    run_nonload_op(lsu_op_pkg::ST_W);
    run_nonload_op(lsu_op_pkg::ST_D);
    run_nonload_op(lsu_op_pkg::SC_W);
    run_nonload_op(lsu_op_pkg::SC_D);
  endtask

  task automatic test_handshake();
    @(posedge clk);
    valid    <= 1'b1;
    lsu_op   <= lsu_op_pkg::LD_W;
    lsu_recv <= 1'b1;
    // access in flight, cache not answered yet
    @(negedge clk) check_bit("lsu_res_valid", 1'b0, lsu_res_valid);
    @(posedge clk) data_data_ok <= 1'b1;
    @(negedge clk) check_bit("lsu_res_valid", 1'b1, lsu_res_valid);
    @(posedge clk) data_data_ok <= 1'b0;
    // result held, cache side blocked
    repeat (2) begin
      @(negedge clk);
      check_bit("lsu_res_valid", 1'b1, lsu_res_valid);
      check_bit("data_recv", 1'b0, data_recv);
    end
    pulse_change();
    wait_released(4);
  endtask

  task automatic test_prefetch_idle();
    // idle with a live access and nothing held still reports done
    @(posedge clk) lsu_op <= lsu_op_pkg::IDLE;
    @(negedge clk) check_bit("lsu_res_valid", 1'b1, lsu_res_valid);
    @(posedge clk) lsu_op <= lsu_op_pkg::PRELD;
    @(negedge clk) check_bit("lsu_res_valid", 1'b1, lsu_res_valid);
    // back to a pending load and drop the held preld result
    @(posedge clk) lsu_op <= lsu_op_pkg::LD_D;
    pulse_change();
    wait_released(4);
  endtask

  task automatic test_fault_capture();
    logic [63:0] addr_a;
    logic [63:0] addr_b;
    logic [63:0] addr_c;
    int          cycles;
    addr_a = {$random(seed), $random(seed)};
    addr_b = ~addr_a;
    addr_c = {$random(seed), $random(seed)};
    raise_fault(addr_a);
    // capture closed, second fault must not overwrite
    @(posedge clk);
    data_exception <= 1'b1;
    data_badvaddr  <= addr_b;
    @(posedge clk) data_exception <= 1'b0;
    @(negedge clk);
    check_bit("badvaddr_valid", 1'b1, badvaddr_valid);
    check_word("badvaddr", addr_a, badvaddr);
    pulse_exception();
    wait_fault_flag(1'b0, 4, cycles);
    // rearm lands on the edge that ends the exception cycle
    check_word("badvaddr_valid latency", 64'd1, 64'(cycles));
    raise_fault(addr_c);
    pulse_exception();
    wait_fault_flag(1'b0, 4, cycles);
    check_word("badvaddr_valid latency", 64'd1, 64'(cycles));
    pulse_change();
  endtask

  initial begin
    seed           = 71;
    err_count      = 0;
    check_count    = 0;
    timeout_count  = 0;
    rst_n          = 1'b0;
    valid          = 1'b0;
    lsu_op         = lsu_op_pkg::IDLE;
    lsu_recv       = 1'b1;
    lsu_shift      = '0;
    data_scsucceed = 1'b0;
    data_rdata     = '0;
    data_exception = 1'b0;
    data_badvaddr  = '0;
    data_data_ok   = 1'b0;
    change         = 1'b0;
    exception      = 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);

    test_reset_state();
    test_loads();
    test_nonloads();
    test_handshake();
    test_prefetch_idle();
    test_fault_capture();

    @(posedge clk) valid <= 1'b0;
    @(negedge clk);
    $display("checks=%0d errors=%0d timeouts=%0d", check_count, err_count, timeout_count);
    if (err_count == 0 && timeout_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
+incdir+rtl
rtl/lsu_op_pkg.sv
rtl/lsu_mem_pkg.sv
rtl/lsu_lane_if.sv
rtl/lsu_op_decode.sv
rtl/lsu_byte_lane.sv
rtl/lsu_result_merge.sv
rtl/lsu_resp_ctrl.sv
rtl/lsu_s2_top.sv
test/tb_lsu_s2.sv

//--- run.sh
#!/bin/sh
# build and run the lsu stage-2 testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_lsu_s2 \
  -Mdir obj_dir -o sim_tb_lsu_s2
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/sim_tb_lsu_s2 > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Verification passed$" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
